/* hw/nn_num_pkg.sv */
package nn_num_pkg;

    ////////////////////////////////////////
    // vector geometry
    ////////////////////////////////////////

    // physical neurons, also length of every vector
    localparam int num_neuron = 4;
    // neuron select counter inside one neuron
    localparam int sel_width = $clog2(num_neuron);

    ////////////////////////////////////////
    // fixed point formats
    ////////////////////////////////////////

    // activations, signed, 8 fraction bits
    localparam int act_width = 9;
    localparam int act_frac = 8;
    // weights, signed
    localparam int weight_width = 17;
    localparam int weight_frac = 8;
    // room for num_neuron full products
    localparam int acc_width = 28;

    // saturation limits of one activation
    localparam int act_max = 2 ** (act_width - 1) - 1;
    localparam int act_min = -(2 ** (act_width - 1));

    // packed bus widths
    localparam int vec_width = num_neuron * act_width;
    localparam int row_width = num_neuron * weight_width;
    localparam int wmat_width = num_neuron * row_width;

    ////////////////////////////////////////
    // layer table
    ////////////////////////////////////////

    localparam int layer_max = 3;
    // holds a layer count 1..layer_max and an index 0..layer_max-1
    localparam int layer_idx_width = 2;

    // active neurons per layer, bit i is neuron i
    // last layer only uses the lower two
    localparam logic [num_neuron-1:0] active_table [layer_max] = '{
        4'b1111,
        4'b1111,
        4'b0011
    };

endpackage

/* hw/nn_ctrl_pkg.sv */
package nn_ctrl_pkg;

    ////////////////////////////////////////
    // layer sequencer FSM
    ////////////////////////////////////////

    // idle waits for run, load is the setup cycle,
    // go issues layer_go, wait sits until layer_done
    typedef enum logic [2:0] {
        seq_idle,
        seq_load,
        seq_go,
        seq_wait,
        seq_done
    } seq_state_t;

    // single neuron FSM
    typedef enum logic [1:0] {
        nrn_idle,
        nrn_accum,
        nrn_finish
    } neuron_state_t;

    // activation applied in the finish cycle
    // relu for hidden layers, linear for the last one
    typedef enum logic {
        act_relu,
        act_linear
    } act_op_t;

endpackage

/* hw/layer_sequencer.sv */
`timescale 1ns/1ps

module layer_sequencer
    import nn_num_pkg::*, nn_ctrl_pkg::*;
(
    input  logic                       start,
    input  logic                       valid_wire,
    input  logic                       run,
    input  logic [vec_width-1:0]       run_input,
    input  logic [layer_idx_width-1:0] layer_count,
    input  logic [vec_width-1:0]       layer_output,
    input  logic                       layer_done,
    output logic                       layer_go,
    output logic [vec_width-1:0]       layer_input,
    output logic [num_neuron-1:0]      active,
    output act_op_t                    act_op,
    output logic [layer_idx_width-1:0] layer_index,
    output logic                       run_accepted,
    output logic                       final_done
);

    seq_state_t state;
    // number of layers latched for the current run
    logic [layer_idx_width-1:0] layer_total;
    logic last_layer;
    logic loop_back;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    assign last_layer = (layer_index == layer_total - 1'b1);

    // run only counts while idle
    assign run_accepted = (state == seq_idle) && run;

    // hidden layer finished, its outputs feed the next one
    assign loop_back = (state == seq_wait) && layer_done && !last_layer;
    // same cycle as the last layer_done
    assign final_done = (state == seq_wait) && layer_done && last_layer;

    assign layer_go = (state == seq_go);

    // per-layer neuron mask and activation
    assign active = active_table[layer_index];
    assign act_op = last_layer ? act_linear : act_relu;

    ////////////////////////////////////////
    // FSM and layer counter
    ////////////////////////////////////////

    always_ff @(posedge start or posedge valid_wire) begin
        if (valid_wire) begin
            state       <= seq_idle;
            layer_index <= '0;
            layer_total <= layer_idx_width'(1);
        end else begin
            case (state)
                seq_idle: begin
                    if (run) begin
                        state       <= seq_load;
                        layer_index <= '0;
                        // zero layers makes no sense, run one
                        if (layer_count == '0) begin
                            layer_total <= layer_idx_width'(1);
                        end else begin
                            layer_total <= layer_count;
                        end
                    end
                end
                // input vector already captured, settle one cycle
                seq_load: state <= seq_go;
                seq_go: state <= seq_wait;
                seq_wait: begin
                    if (loop_back) begin
                        state       <= seq_go;
                        layer_index <= layer_index + 1'b1;
                    end else if (final_done) begin
                        state <= seq_done;
                    end
                end
                // one tail cycle before new runs are taken
                seq_done: state <= seq_idle;
                default: state <= seq_idle;
            endcase
        end
    end

    // input vector register
    // first layer gets run_input, later layers the previous outputs
    always_ff @(posedge start) begin
        if (run_accepted) begin
            layer_input <= run_input;
        end else if (loop_back) begin
            layer_input <= layer_output;
        end
    end

endmodule

/* hw/neuron_mac.sv */
`timescale 1ns/1ps

module neuron_mac
    import nn_num_pkg::*, nn_ctrl_pkg::*;
(
    input  logic                 start,
    input  logic                 valid_wire,
    input  logic                 go,
    input  logic                 enable,
    input  act_op_t              act_op,
    input  logic [vec_width-1:0] inputs,
    input  logic [row_width-1:0] weight_row,
    output logic [act_width-1:0] value,
    output logic                 done
);

    neuron_state_t state;
    // which input and weight pair is multiplied this cycle
    logic [sel_width-1:0] sel;
    logic signed [act_width-1:0] in_sel;
    logic signed [weight_width-1:0] w_sel;
    logic signed [acc_width-1:0] product;
    logic signed [acc_width-1:0] acc;
    logic signed [acc_width-1:0] shifted;
    logic signed [acc_width-1:0] activated;
    logic [act_width-1:0] saturated;

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    assign in_sel = inputs[sel*act_width +: act_width];
    assign w_sel = weight_row[sel*weight_width +: weight_width];
    // both operands signed, widened to the accumulator
    assign product = in_sel * w_sel;

    // back to activation fraction bits
    assign shifted = acc >>> weight_frac;

    always_comb begin
        activated = shifted;
        // relu clips negatives
        if (act_op == act_relu && shifted[acc_width-1]) begin
            activated = '0;
        end
        // clamp to the signed activation range
        if (activated > act_max) begin
            saturated = act_width'(act_max);
        end else if (activated < act_min) begin
            saturated = act_width'(act_min);
        end else begin
            saturated = activated[act_width-1:0];
        end
    end

    // first product lands on go, the rest in accum
    always_ff @(posedge start) begin
        if (state == nrn_idle && go) begin
            acc <= product;
        end else if (state == nrn_accum) begin
            acc <= acc + product;
        end
    end

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_ff @(posedge start or posedge valid_wire) begin
        if (valid_wire) begin
            state <= nrn_idle;
            sel   <= '0;
            value <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                nrn_idle: begin
                    if (go && enable) begin
                        state <= nrn_accum;
                        sel   <= sel_width'(1);
                    end else if (go) begin
                        // disabled for this layer, zero and no done
                        value <= '0;
                    end
                end
                nrn_accum: begin
                    sel <= sel + 1'b1;
                    if (sel == sel_width'(num_neuron - 1)) begin
                        state <= nrn_finish;
                    end
                end
                nrn_finish: begin
                    value <= saturated;
                    done  <= 1'b1;
                    sel   <= '0;
                    state <= nrn_idle;
                end
                default: state <= nrn_idle;
            endcase
        end
    end

endmodule

/* hw/neuron_layer.sv */
`timescale 1ns/1ps

module neuron_layer
    import nn_num_pkg::*, nn_ctrl_pkg::*;
(
    input  logic                  start,
    input  logic                  valid_wire,
    input  logic                  layer_go,
    input  logic [num_neuron-1:0] active,
    input  act_op_t               act_op,
    input  logic [vec_width-1:0]  layer_input,
    input  logic [wmat_width-1:0] weights,
    output logic [vec_width-1:0]  layer_output,
    output logic                  layer_done
);

    logic [num_neuron-1:0] neuron_done;
    // done bits seen so far in this layer
    logic [num_neuron-1:0] done_seen;
    logic [num_neuron-1:0] done_all;

    // shared input vector, one weight row per neuron
    for (genvar i = 0; i < num_neuron; i++) begin : g_neuron
        neuron_mac u_neuron (
            .start      (start),
            .valid_wire (valid_wire),
            .go         (layer_go),
            .enable     (active[i]),
            .act_op     (act_op),
            .inputs     (layer_input),
            .weight_row (weights[i*row_width +: row_width]),
            .value      (layer_output[i*act_width +: act_width]),
            .done       (neuron_done[i])
        );
    end

    assign done_all = done_seen | neuron_done;

    // registered completion check
    // fires once when the done set matches the mask
    always_ff @(posedge start or posedge valid_wire) begin
        if (valid_wire) begin
            done_seen  <= '0;
            layer_done <= 1'b0;
        end else if (layer_go) begin
            done_seen  <= '0;
            layer_done <= 1'b0;
        end else if (|neuron_done && done_all == active) begin
            done_seen  <= '0;
            layer_done <= 1'b1;
        end else begin
            done_seen  <= done_all;
            layer_done <= 1'b0;
        end
    end

endmodule

/* hw/result_capture.sv */
`timescale 1ns/1ps

module result_capture
    import nn_num_pkg::*;
(
    input  logic                 start,
    input  logic                 valid_wire,
    input  logic                 run_accepted,
    input  logic                 final_done,
    input  logic [vec_width-1:0] layer_output,
    output logic [vec_width-1:0] final_output,
    output logic                 result_valid
);

    ////////////////////////////////////////
    // result hold register
    ////////////////////////////////////////

    // valid is a level
    // drops on a new run, old vector stays visible meanwhile
    always_ff @(posedge start or posedge valid_wire) begin
        if (valid_wire) begin
            result_valid <= 1'b0;
        end else if (run_accepted) begin
            result_valid <= 1'b0;
        end else if (final_done) begin
            result_valid <= 1'b1;
        end
    end

    // vector and flag update on the same edge
    // so valid never rises ahead of the data
    always_ff @(posedge start or posedge valid_wire) begin
        if (valid_wire) begin
            final_output <= '0;
        end else if (final_done) begin
            final_output <= layer_output;
        end
    end

endmodule

/* hw/forward_net.sv */
`timescale 1ns/1ps

module forward_net
    import nn_num_pkg::*, nn_ctrl_pkg::*;
(
    input  logic                       start,
    input  logic                       valid_wire,
    input  logic                       run,
    input  logic [vec_width-1:0]       run_input,
    input  logic [layer_idx_width-1:0] layer_count,
    input  logic [wmat_width-1:0]      weights,
    output logic [layer_idx_width-1:0] layer_index,
    output logic [vec_width-1:0]       final_output,
    output logic                       result_valid
);

    ////////////////////////////////////////
    // sequencer to layer
    ////////////////////////////////////////

    logic                  layer_go;
    logic [vec_width-1:0]  layer_input;
    logic [num_neuron-1:0] active;
    act_op_t               act_op;

    // layer back to sequencer and capture
    logic [vec_width-1:0] layer_output;
    logic                 layer_done;

    // sequencer to capture
    logic run_accepted;
    logic final_done;

    layer_sequencer u_sequencer (
        .start        (start),
        .valid_wire   (valid_wire),
        .run          (run),
        .run_input    (run_input),
        .layer_count  (layer_count),
        .layer_output (layer_output),
        .layer_done   (layer_done),
        .layer_go     (layer_go),
        .layer_input  (layer_input),
        .active       (active),
        .act_op       (act_op),
        .layer_index  (layer_index),
        .run_accepted (run_accepted),
        .final_done   (final_done)
    );

    // one physical layer reused for every network layer
    neuron_layer u_layer (
        .start        (start),
        .valid_wire   (valid_wire),
        .layer_go     (layer_go),
        .active       (active),
        .act_op       (act_op),
        .layer_input  (layer_input),
        .weights      (weights),
        .layer_output (layer_output),
        .layer_done   (layer_done)
    );

    result_capture u_capture (
        .start        (start),
        .valid_wire   (valid_wire),
        .run_accepted (run_accepted),
        .final_done   (final_done),
        .layer_output (layer_output),
        .final_output (final_output),
        .result_valid (result_valid)
    );

endmodule

/* tb/forward_net_model.svh */
`ifndef FORWARD_NET_MODEL_SVH
`define FORWARD_NET_MODEL_SVH

// one pass through the shared neuron layer
// mask zeroes inactive neurons, relu picks the hidden activation
function automatic logic [vec_width-1:0] model_layer(
    input logic [vec_width-1:0]  vin,
    input logic [wmat_width-1:0] wmat,
    input logic [num_neuron-1:0] mask,
    input bit                    relu
);
    logic [vec_width-1:0] vout;
    int sum;
    int x;
    int w;
    int lim_hi;
    int lim_lo;
    vout = '0;
    lim_hi = (1 <<< (act_width - 1)) - 1;
    lim_lo = -(1 <<< (act_width - 1));
    for (int i = 0; i < num_neuron; i++) begin
        sum = 0;
        for (int j = 0; j < num_neuron; j++) begin
            x = int'($signed(vin[j*act_width +: act_width]));
            w = int'($signed(wmat[i*row_width + j*weight_width +: weight_width]));
            sum = sum + x * w;
        end
        // drop the weight fraction, rounds toward minus infinity
        sum = sum >>> weight_frac;
        if (relu && sum < 0) begin
            sum = 0;
        end
        // clamp into the signed activation range
        if (sum > lim_hi) begin
            sum = lim_hi;
        end else if (sum < lim_lo) begin
            sum = lim_lo;
        end
        if (!mask[i]) begin
            sum = 0;
        end
        vout[i*act_width +: act_width] = act_width'(sum);
    end
    return vout;
endfunction

// whole network, outputs of each layer loop back as inputs
function automatic logic [vec_width-1:0] model_net(
    input logic [vec_width-1:0]                  vin,
    input int                                    n_layers,
    input logic [layer_max-1:0][wmat_width-1:0] wset
);
    logic [vec_width-1:0] v;
    v = vin;
    for (int l = 0; l < n_layers; l++) begin
        // last layer is linear
        v = model_layer(v, wset[l], active_table[l], l != n_layers - 1);
    end
    return v;
endfunction

`endif

/* tb/forward_net_tb.sv */
`timescale 1ns/1ps

module forward_net_tb
    import nn_num_pkg::*;
();

    localparam int half_period = 20;
    localparam int drive_delay = 2;
    localparam int n_random = 8;
    // three directed runs, the ignored pulse run, then random ones
    localparam int n_runs = 4 + n_random;
    // load and go, per layer go to done and loop back, gaps between runs
    localparam int run_cycles = 2 + layer_max * (num_neuron + 4) + 8;
    localparam int timeout_cycles = n_runs * run_cycles + 40;

    logic                              start;
    logic                              valid_wire;
    logic                              run;
    logic [vec_width-1:0]              run_input;
    logic [layer_idx_width-1:0]        layer_count;
    logic [wmat_width-1:0]             weights;
    logic [layer_idx_width-1:0]        layer_index;
    logic [vec_width-1:0]              final_output;
    logic                              result_valid;

    // weight matrix per layer, picked by layer_index
    logic [layer_max-1:0][wmat_width-1:0] layer_w;
    logic [vec_width-1:0] exp_out;
    logic [vec_width-1:0] vec_a;
    int cur_layers;
    int seed;
    int errors;
    int checks;
    int cycles;

    `include "forward_net_model.svh"

    forward_net forward_net_i (
        .start        (start),
        .valid_wire   (valid_wire),
        .run          (run),
        .run_input    (run_input),
        .layer_count  (layer_count),
        .weights      (weights),
        .layer_index  (layer_index),
        .final_output (final_output),
        .result_valid (result_valid)
    );

    always #(half_period) start = ~start;

    // weights follow the layer now computing
    always @(posedge start) begin
        #(drive_delay);
        weights = layer_w[layer_index];
    end

    // run length guard
    always @(posedge start) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles, result_valid never came back", cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////

    // new result already in place when valid rises
    valid_rise_data: assert property (@(posedge start) disable iff (valid_wire)
        $rose(result_valid) |-> final_output == exp_out)
        else begin
            errors++;
            $display("ERROR final_output %h expected %h", final_output, exp_out);
        end

    // held result does not move
    result_stable: assert property (@(posedge start) disable iff (valid_wire)
        (result_valid && $past(result_valid)) |-> final_output == $past(final_output))
        else begin
            errors++;
            $display("ERROR final_output %h changed while result_valid high", final_output);
        end

    // one step per layer, back to zero on a new run
    index_step: assert property (@(posedge start) disable iff (valid_wire)
        (layer_index != $past(layer_index)) |->
            ((layer_index == $past(layer_index) + 2'd1) || (layer_index == '0)))
        else begin
            errors++;
            $display("ERROR layer_index %h skipped a layer", layer_index);
        end

    index_bound: assert property (@(posedge start) disable iff (valid_wire)
        !result_valid |-> int'(layer_index) < cur_layers)
        else begin
            errors++;
            $display("ERROR layer_index %h beyond layer count %h", layer_index, cur_layers);
        end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check_equal(input string name, input logic [vec_width-1:0] got,
                               input logic [vec_width-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge start);
    endtask

    task automatic set_weight(input int l, input int i, input int j, input int val);
        layer_w[l][i*row_width + j*weight_width +: weight_width] = weight_width'(val);
    endtask

    function automatic logic [vec_width-1:0] make_vec(input int a, input int b,
                                                      input int c, input int d);
        return {act_width'(d), act_width'(c), act_width'(b), act_width'(a)};
    endfunction

    function automatic logic [vec_width-1:0] random_vector();
        logic [vec_width-1:0] v;
        for (int i = 0; i < num_neuron; i++) begin
            v[i*act_width +: act_width] = act_width'($random(seed) % 256);
        end
        return v;
    endfunction

    // layer 0 gives negative odd neurons, layer 1 saturates, layer 2 halves
    task automatic fill_directed_weights();
        for (int l = 0; l < layer_max; l++) begin
            for (int i = 0; i < num_neuron; i++) begin
                for (int j = 0; j < num_neuron; j++) begin
                    case (l)
                        0: set_weight(l, i, j, (i % 2 == 1) ? -256 : 256);
                        1: set_weight(l, i, j, (i == 1) ? -2048 : 2048);
                        default: set_weight(l, i, j, (i == j) ? 128 : 0);
                    endcase
                end
            end
        end
    endtask

    task automatic fill_random_weights();
        for (int l = 0; l < layer_max; l++) begin
            for (int i = 0; i < num_neuron; i++) begin
                for (int j = 0; j < num_neuron; j++) begin
                    set_weight(l, i, j, $random(seed) % 384);
                end
            end
        end
    endtask

    task automatic pulse_run(input logic [vec_width-1:0] vin, input int count);
        @(posedge start);
        #(drive_delay);
        run = 1'b1;
        run_input = vin;
        layer_count = layer_idx_width'(count);
        @(posedge start);
        #(drive_delay);
        run = 1'b0;
    endtask

    task automatic wait_result();
        while (result_valid !== 1'b1) begin
            @(posedge start);
            #(drive_delay);
        end
    endtask

    // full run, valid drops right away and the result matches the model
    task automatic run_and_check(input logic [vec_width-1:0] vin, input int count);
        exp_out = model_net(vin, count, layer_w);
        cur_layers = count;
        pulse_run(vin, count);
        check_equal("result_valid", vec_width'(result_valid), '0);
        wait_result();
        check_equal("final_output", final_output, exp_out);
        wait_cycles(2);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        seed = 76808;
        errors = 0;
        checks = 0;
        cycles = 0;
        cur_layers = 1;
        start = 1'b0;
        valid_wire = 1'b1;
        run = 1'b0;
        run_input = '0;
        layer_count = layer_idx_width'(1);
        weights = '0;
        layer_w = '0;
        exp_out = '0;
        repeat (3) @(posedge start);
        #(drive_delay);
        valid_wire = 1'b0;
        check_equal("result_valid", vec_width'(result_valid), '0);
        check_equal("final_output", final_output, '0);
        check_equal("layer_index", vec_width'(layer_index), '0);

        fill_directed_weights();
        vec_a = make_vec(100, 50, 20, 10);
        for (int n = 1; n <= layer_max; n++) begin
            run_and_check(vec_a, n);
        end

        // second pulse lands mid computation and must be dropped
        exp_out = model_net(vec_a, 3, layer_w);
        cur_layers = 3;
        pulse_run(vec_a, 3);
        wait_cycles(4);
        pulse_run(make_vec(-200, 7, 90, -3), 1);
        wait_result();
        check_equal("final_output", final_output, exp_out);
        wait_cycles(2);

        for (int r = 0; r < n_random; r++) begin
            fill_random_weights();
            run_and_check(random_vector(), 1 + int'($unsigned($random(seed)) % layer_max));
        end

        wait_cycles(2);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+tb
hw/nn_num_pkg.sv
hw/nn_ctrl_pkg.sv
hw/layer_sequencer.sv
hw/neuron_mac.sv
hw/neuron_layer.sv
hw/result_capture.sv
hw/forward_net.sv
tb/forward_net_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the forward_net testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module forward_net_tb \
    -o forward_net_sim

./obj_dir/forward_net_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail"
    exit 1
fi
